// ==== logic/rvDecodePkg.sv ====
package rvDecodePkg;

    // ====================================================================
    // Widths
    // ====================================================================
    localparam int XLEN       = 32;
    localparam int REG_NAME_W = 5;
    localparam int INST_W     = 32;
    localparam int NUM_REGS   = 2 ** REG_NAME_W;

    typedef logic [XLEN-1:0]       wordT;     // Data, PC and immediate
    typedef logic [INST_W-1:0]     instT;
    typedef logic [REG_NAME_W-1:0] regNameT;

    // Predicted-jump flag from fetch
    localparam logic NOT_JUMP = 1'b0;
    localparam logic DO_JUMP  = 1'b1;

    // ====================================================================
    // Major opcodes, inst[6:0]
    // ====================================================================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Internal operation code handed to execute
    typedef enum logic [5:0] {
        NOP,
        LUI,
        AUIPC,
        JAL,
        JALR,
        // Branches
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        // Loads and stores
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        // Register-immediate
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        // Register-register
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } opT;

endpackage

// ==== logic/decodeBus.sv ====
`timescale 1ns/1ps

// One decoded instruction on its way to operand fetch and issue
interface decodeBus;

    logic                 en;
    rvDecodePkg::opT      op;
    rvDecodePkg::regNameT rs1;
    rvDecodePkg::regNameT rs2;
    rvDecodePkg::regNameT rd;
    rvDecodePkg::wordT    imm;
    rvDecodePkg::wordT    pc;
    logic                 pd;     // Predicted jump, passed through

    modport source (
        output en, op, rs1, rs2, rd, imm, pc, pd
    );

    // Register file only needs the source names
    modport names (
        input rs1, rs2
    );

    modport sink (
        input en, op, rs1, rs2, rd, imm, pc, pd
    );

endinterface

// ==== logic/instDecoder.sv ====
`timescale 1ns/1ps

module instDecoder (
    input  logic              rst,
    input  logic              rdy,
    input  logic              fetchEn,
    input  rvDecodePkg::instT fetchInst,
    input  rvDecodePkg::wordT fetchPc,
    input  logic              fetchPd,
    decodeBus.source          bus
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;      // inst[30], selects SUB / SRA / SRAI

    assign opcode = fetchInst[6:0];
    assign funct3 = fetchInst[14:12];
    assign alt    = fetchInst[30];

    // ====================================================================
    // Fixed fields
    // ====================================================================
    assign bus.en  = rdy && fetchEn && !rst;
    assign bus.pc  = fetchPc;
    assign bus.pd  = fetchPd;
    assign bus.rs1 = fetchInst[19:15];
    assign bus.rs2 = fetchInst[24:20];
    assign bus.rd  = fetchInst[11:7];

    // ====================================================================
    // Immediate by format
    // ====================================================================
    always_comb begin
        case (opcode)
            rvDecodePkg::OPC_LUI,
            rvDecodePkg::OPC_AUIPC: begin
                bus.imm = {fetchInst[31:12], 12'b0};
            end
            rvDecodePkg::OPC_JAL: begin
                bus.imm = {{(rvDecodePkg::XLEN - 20){fetchInst[31]}}, fetchInst[19:12],
                           fetchInst[20], fetchInst[30:21], 1'b0};
            end
            rvDecodePkg::OPC_BRANCH: begin
                bus.imm = {{(rvDecodePkg::XLEN - 12){fetchInst[31]}}, fetchInst[7],
                           fetchInst[30:25], fetchInst[11:8], 1'b0};
            end
            rvDecodePkg::OPC_JALR,
            rvDecodePkg::OPC_LOAD,
            rvDecodePkg::OPC_OPIMM: begin
                bus.imm = {{(rvDecodePkg::XLEN - 11){fetchInst[31]}}, fetchInst[30:20]};
            end
            rvDecodePkg::OPC_STORE: begin
                bus.imm = {{(rvDecodePkg::XLEN - 11){fetchInst[31]}}, fetchInst[30:25],
                           fetchInst[11:7]};
            end
            default: begin
                bus.imm = '0;
            end
        endcase
    end

    // ====================================================================
    // Operation code
    // ====================================================================
    always_comb begin
        bus.op = rvDecodePkg::NOP;    // Undefined encodings fall through to this
        case (opcode)
            rvDecodePkg::OPC_LUI:   bus.op = rvDecodePkg::LUI;
            rvDecodePkg::OPC_AUIPC: bus.op = rvDecodePkg::AUIPC;
            rvDecodePkg::OPC_JAL:   bus.op = rvDecodePkg::JAL;
            rvDecodePkg::OPC_JALR:  bus.op = rvDecodePkg::JALR;
            rvDecodePkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000:  bus.op = rvDecodePkg::BEQ;
                    3'b001:  bus.op = rvDecodePkg::BNE;
                    3'b100:  bus.op = rvDecodePkg::BLT;
                    3'b101:  bus.op = rvDecodePkg::BGE;
                    3'b110:  bus.op = rvDecodePkg::BLTU;
                    3'b111:  bus.op = rvDecodePkg::BGEU;
                    default: bus.op = rvDecodePkg::NOP;
                endcase
            end
            rvDecodePkg::OPC_LOAD: begin
                case (funct3)
                    3'b000:  bus.op = rvDecodePkg::LB;
                    3'b001:  bus.op = rvDecodePkg::LH;
                    3'b010:  bus.op = rvDecodePkg::LW;
                    3'b100:  bus.op = rvDecodePkg::LBU;
                    3'b101:  bus.op = rvDecodePkg::LHU;
                    default: bus.op = rvDecodePkg::NOP;
                endcase
            end
            rvDecodePkg::OPC_STORE: begin
                case (funct3)
                    3'b000:  bus.op = rvDecodePkg::SB;
                    3'b001:  bus.op = rvDecodePkg::SH;
                    3'b010:  bus.op = rvDecodePkg::SW;
                    default: bus.op = rvDecodePkg::NOP;
                endcase
            end
            rvDecodePkg::OPC_OPIMM: begin
                // Bit 30 is immediate data except for the shifts
                case (funct3)
                    3'b000:  bus.op = rvDecodePkg::ADDI;
                    3'b010:  bus.op = rvDecodePkg::SLTI;
                    3'b011:  bus.op = rvDecodePkg::SLTIU;
                    3'b100:  bus.op = rvDecodePkg::XORI;
                    3'b110:  bus.op = rvDecodePkg::ORI;
                    3'b111:  bus.op = rvDecodePkg::ANDI;
                    3'b001:  bus.op = alt ? rvDecodePkg::NOP : rvDecodePkg::SLLI;
                    default: bus.op = alt ? rvDecodePkg::SRAI : rvDecodePkg::SRLI;
                endcase
            end
            rvDecodePkg::OPC_OP: begin
                case ({alt, funct3})
                    4'b0000: bus.op = rvDecodePkg::ADD;
                    4'b1000: bus.op = rvDecodePkg::SUB;
                    4'b0001: bus.op = rvDecodePkg::SLL;
                    4'b0010: bus.op = rvDecodePkg::SLT;
                    4'b0011: bus.op = rvDecodePkg::SLTU;
                    4'b0100: bus.op = rvDecodePkg::XOR;
                    4'b0101: bus.op = rvDecodePkg::SRL;
                    4'b1101: bus.op = rvDecodePkg::SRA;
                    4'b0110: bus.op = rvDecodePkg::OR;
                    4'b0111: bus.op = rvDecodePkg::AND;
                    default: bus.op = rvDecodePkg::NOP;
                endcase
            end
            default: bus.op = rvDecodePkg::NOP;
        endcase
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                 clk,
    input  logic                 rst,
    decodeBus.names              bus,
    input  logic                 wbEn,
    input  rvDecodePkg::regNameT wbRd,
    input  rvDecodePkg::wordT    wbData,
    output rvDecodePkg::wordT    rs1Val,
    output rvDecodePkg::wordT    rs2Val
);

    rvDecodePkg::wordT regs [1:rvDecodePkg::NUM_REGS-1];   // x0 has no storage
    logic              wrHit;

    assign wrHit = wbEn && (wbRd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < rvDecodePkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrHit) begin
            regs[wbRd] <= wbData;
        end
    end

    // Read with x0 tied low and bypass from the write port
    function automatic rvDecodePkg::wordT readReg(input rvDecodePkg::regNameT name);
        rvDecodePkg::wordT val;
        if (name == '0) begin
            val = '0;
        end else if (wrHit && (wbRd == name)) begin
            val = wbData;
        end else begin
            val = regs[name];
        end
        return val;
    endfunction

    always_comb begin
        rs1Val = readReg(bus.rs1);
        rs2Val = readReg(bus.rs2);
    end

    // A write aimed at x0 must not show up on a later read of x0
    property x0StaysZero;
        @(posedge clk) disable iff (rst)
        (wbEn && (wbRd == '0)) |=>
            ((bus.rs1 != '0) || (rs1Val == '0)) && ((bus.rs2 != '0) || (rs2Val == '0));
    endproperty

    assert property (x0StaysZero)
        else $error("regFile: read of x0 nonzero after write to x0");

endmodule

// ==== logic/operandIssue.sv ====
`timescale 1ns/1ps

module operandIssue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    decodeBus.sink               bus,
    input  rvDecodePkg::wordT    rs1Val,
    input  rvDecodePkg::wordT    rs2Val,

    // To execute
    output logic                 exEn,
    output rvDecodePkg::opT      exOp,
    output rvDecodePkg::wordT    exPc,
    output rvDecodePkg::wordT    exImm,
    output rvDecodePkg::wordT    exRs1Val,
    output rvDecodePkg::wordT    exRs2Val,
    output rvDecodePkg::regNameT exRd,
    output logic                 exPd
);

    // ====================================================================
    // Issue register
    // ====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            exEn     <= 1'b0;
            exOp     <= rvDecodePkg::NOP;
            exPc     <= '0;
            exImm    <= '0;
            exRs1Val <= '0;
            exRs2Val <= '0;
            exRd     <= '0;
            exPd     <= rvDecodePkg::NOT_JUMP;
        end else if (rdy) begin
            exEn <= bus.en;
            if (bus.en) begin     // Gap cycles keep the last payload
                exOp     <= bus.op;
                exPc     <= bus.pc;
                exImm    <= bus.imm;
                exRs1Val <= rs1Val;
                exRs2Val <= rs2Val;
                exRd     <= bus.rd;
                exPd     <= bus.pd;
            end
        end
        // Stall, execute is not consuming
    end

    // ====================================================================
    // Checks
    // ====================================================================
    property enKnown;
        @(posedge clk) disable iff (rst)
        !$isunknown(exEn);
    endproperty

    assert property (enKnown)
        else $error("operandIssue: exEn unknown out of reset");

    // Nothing may move on the execute side while the stage is stalled
    property holdOnStall;
        @(posedge clk) disable iff (rst)
        !rdy |=> $stable({exEn, exOp, exPc, exImm, exRs1Val, exRs2Val, exRd, exPd});
    endproperty

    assert property (holdOnStall)
        else $error("operandIssue: outputs changed while rdy low");

endmodule

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,

    // Fetch side
    input  logic                 fetchEn,
    input  rvDecodePkg::instT    fetchInst,
    input  rvDecodePkg::wordT    fetchPc,
    input  logic                 fetchPd,

    // Write-back from execute
    input  logic                 wbEn,
    input  rvDecodePkg::regNameT wbRd,
    input  rvDecodePkg::wordT    wbData,

    // Issue to execute
    output logic                 exEn,
    output rvDecodePkg::opT      exOp,
    output rvDecodePkg::wordT    exPc,
    output rvDecodePkg::wordT    exImm,
    output rvDecodePkg::wordT    exRs1Val,
    output rvDecodePkg::wordT    exRs2Val,
    output rvDecodePkg::regNameT exRd,
    output logic                 exPd
);

    rvDecodePkg::wordT rs1Val;
    rvDecodePkg::wordT rs2Val;

    decodeBus dec ();

    instDecoder decoder (
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchInst (fetchInst),
        .fetchPc   (fetchPc),
        .fetchPd   (fetchPd),
        .bus       (dec.source)
    );

    regFile rf (
        .clk    (clk),
        .rst    (rst),
        .bus    (dec.names),
        .wbEn   (wbEn),
        .wbRd   (wbRd),
        .wbData (wbData),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val)
    );

    // One cycle from accept to execute
    operandIssue issue (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .bus      (dec.sink),
        .rs1Val   (rs1Val),
        .rs2Val   (rs2Val),
        .exEn     (exEn),
        .exOp     (exOp),
        .exPc     (exPc),
        .exImm    (exImm),
        .exRs1Val (exRs1Val),
        .exRs2Val (exRs2Val),
        .exRd     (exRd),
        .exPd     (exPd)
    );

endmodule

// ==== tests/decodeStageTb.sv ====
`timescale 1ns/1ps

module decodeStageTb;

    localparam int TEST_CYCLES = 316;     // Sum of all directed and random tests
    localparam int MARGIN      = 200;

    logic clk, rst, rdy, fetchEn, fetchPd, wbEn, exEn, exPd;
    rvDecodePkg::instT    fetchInst;
    rvDecodePkg::wordT    fetchPc, wbData, exPc, exImm, exRs1Val, exRs2Val;
    rvDecodePkg::regNameT wbRd, exRd;
    rvDecodePkg::opT      exOp;

    rvDecodePkg::wordT shadow [32];        // Reference copy of the register file
    logic [31:0]       lfsr = 32'hcb6;
    int                errors = 0;
    int                checks = 0;

    decodeStage dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================================================================
    // Random source and reference model
    // ====================================================================
    function automatic logic nextBit();
        logic b;
        b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], b};
        return b;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], nextBit()};
        end
        return r;
    endfunction

    function automatic rvDecodePkg::opT modelOp(input rvDecodePkg::instT i);
        logic [2:0]      f3;
        logic            b30;
        rvDecodePkg::opT op;
        f3  = i[14:12];
        b30 = i[30];
        op  = rvDecodePkg::NOP;
        if (i[6:0] == rvDecodePkg::OPC_LUI) op = rvDecodePkg::LUI;
        if (i[6:0] == rvDecodePkg::OPC_AUIPC) op = rvDecodePkg::AUIPC;
        if (i[6:0] == rvDecodePkg::OPC_JAL) op = rvDecodePkg::JAL;
        if (i[6:0] == rvDecodePkg::OPC_JALR) op = rvDecodePkg::JALR;
        if (i[6:0] == rvDecodePkg::OPC_BRANCH) begin
            case (f3)
                0: op = rvDecodePkg::BEQ;
                1: op = rvDecodePkg::BNE;
                4: op = rvDecodePkg::BLT;
                5: op = rvDecodePkg::BGE;
                6: op = rvDecodePkg::BLTU;
                7: op = rvDecodePkg::BGEU;
                default: op = rvDecodePkg::NOP;
            endcase
        end
        if (i[6:0] == rvDecodePkg::OPC_LOAD) begin
            case (f3)
                0: op = rvDecodePkg::LB;
                1: op = rvDecodePkg::LH;
                2: op = rvDecodePkg::LW;
                4: op = rvDecodePkg::LBU;
                5: op = rvDecodePkg::LHU;
                default: op = rvDecodePkg::NOP;
            endcase
        end
        if (i[6:0] == rvDecodePkg::OPC_STORE && f3 == 0) op = rvDecodePkg::SB;
        if (i[6:0] == rvDecodePkg::OPC_STORE && f3 == 1) op = rvDecodePkg::SH;
        if (i[6:0] == rvDecodePkg::OPC_STORE && f3 == 2) op = rvDecodePkg::SW;
        if (i[6:0] == rvDecodePkg::OPC_OPIMM) begin
            case (f3)
                0: op = rvDecodePkg::ADDI;
                1: op = b30 ? rvDecodePkg::NOP : rvDecodePkg::SLLI;
                2: op = rvDecodePkg::SLTI;
                3: op = rvDecodePkg::SLTIU;
                4: op = rvDecodePkg::XORI;
                5: op = b30 ? rvDecodePkg::SRAI : rvDecodePkg::SRLI;
                6: op = rvDecodePkg::ORI;
                default: op = rvDecodePkg::ANDI;
            endcase
        end
        if (i[6:0] == rvDecodePkg::OPC_OP) begin
            case (f3)
                0: op = b30 ? rvDecodePkg::SUB : rvDecodePkg::ADD;
                1: op = rvDecodePkg::SLL;
                2: op = rvDecodePkg::SLT;
                3: op = rvDecodePkg::SLTU;
                4: op = rvDecodePkg::XOR;
                5: op = b30 ? rvDecodePkg::SRA : rvDecodePkg::SRL;
                6: op = rvDecodePkg::OR;
                default: op = rvDecodePkg::AND;
            endcase
            if (b30 && f3 != 0 && f3 != 5) op = rvDecodePkg::NOP;  // Only SUB and SRA use it
        end
        return op;
    endfunction

    function automatic rvDecodePkg::wordT modelImm(input rvDecodePkg::instT i);
        logic [6:0] opc;
        opc = i[6:0];
        if (opc == rvDecodePkg::OPC_LUI || opc == rvDecodePkg::OPC_AUIPC)
            return {i[31:12], 12'h000};
        if (opc == rvDecodePkg::OPC_JAL)
            return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
        if (opc == rvDecodePkg::OPC_BRANCH)
            return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
        if (opc == rvDecodePkg::OPC_STORE)
            return {{20{i[31]}}, i[31:25], i[11:7]};
        if (opc == rvDecodePkg::OPC_JALR || opc == rvDecodePkg::OPC_LOAD ||
            opc == rvDecodePkg::OPC_OPIMM)
            return {{20{i[31]}}, i[31:20]};
        return '0;
    endfunction

    // ====================================================================
    // Check and drive helpers
    // ====================================================================
    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expectEx(input logic en, input rvDecodePkg::opT op,
                            input rvDecodePkg::wordT pc, input rvDecodePkg::wordT imm,
                            input rvDecodePkg::wordT r1, input rvDecodePkg::wordT r2,
                            input rvDecodePkg::regNameT rd, input logic pd);
        checkEq(32'(exEn), 32'(en), "exEn");
        checkEq(32'(exOp), 32'(op), "exOp");
        checkEq(exPc, pc, "exPc");
        checkEq(exImm, imm, "exImm");
        checkEq(exRs1Val, r1, "exRs1Val");
        checkEq(exRs2Val, r2, "exRs2Val");
        checkEq(32'(exRd), 32'(rd), "exRd");
        checkEq(32'(exPd), 32'(pd), "exPd");
    endtask

    function automatic rvDecodePkg::wordT readModel(input rvDecodePkg::regNameT r,
                                                    input logic we, input rvDecodePkg::regNameT wr,
                                                    input rvDecodePkg::wordT wd);
        if (r == 0) return '0;
        if (we && wr == r) return wd;      // Same-cycle write seen through bypass
        return shadow[r];
    endfunction

    // Called 1 ns after an edge; leaves the inputs driven for back-to-back use
    task automatic sendInst(input rvDecodePkg::instT inst, input rvDecodePkg::wordT pc,
                            input logic pd, input logic we, input rvDecodePkg::regNameT wr,
                            input rvDecodePkg::wordT wd);
        rvDecodePkg::wordT r1, r2;
        r1 = readModel(inst[19:15], we, wr, wd);
        r2 = readModel(inst[24:20], we, wr, wd);
        rdy = 1'b1;
        fetchEn = 1'b1;
        fetchInst = inst;
        fetchPc = pc;
        fetchPd = pd;
        wbEn = we;
        wbRd = wr;
        wbData = wd;
        if (we && wr != 0) shadow[wr] = wd;
        @(posedge clk);
        #1;
        expectEx(1'b1, modelOp(inst), pc, modelImm(inst), r1, r2, inst[11:7], pd);
    endtask

    task automatic idleCycle(input logic we, input rvDecodePkg::regNameT wr,
                             input rvDecodePkg::wordT wd);
        fetchEn = 1'b0;
        wbEn = we;
        wbRd = wr;
        wbData = wd;
        if (we && wr != 0) shadow[wr] = wd;
        @(posedge clk);
        #1;
        wbEn = 1'b0;
    endtask

    // ====================================================================
    // Directed tests
    // ====================================================================
    task automatic resetTest();
        repeat (2) @(posedge clk);
        #1;
        expectEx(1'b0, rvDecodePkg::NOP, '0, '0, '0, '0, '0, rvDecodePkg::NOT_JUMP);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        idleCycle(1'b0, '0, '0);
        expectEx(1'b0, rvDecodePkg::NOP, '0, '0, '0, '0, '0, rvDecodePkg::NOT_JUMP);
    endtask

    task automatic immFormatTest();
        rvDecodePkg::instT words [16];
        words = '{32'hfffff0b7, 32'h12345137, 32'h80000197, 32'h00001217,
                  32'hffdff0ef, 32'h0080006f, 32'hfe208ee3, 32'h00208463,
                  32'hffc08067, 32'h00408067, 32'hff852283, 32'h01052283,
                  32'hfe512e23, 32'h00512823, 32'hfff00093, 32'h7ff00093};
        foreach (words[k]) begin
            sendInst(words[k], 32'h1000 + 32'(k * 4), k[0], 1'b0, '0, '0);
        end
    endtask

    task automatic opMapTest();
        logic [6:0] opcs [5];
        opcs = '{rvDecodePkg::OPC_BRANCH, rvDecodePkg::OPC_LOAD, rvDecodePkg::OPC_STORE,
                 rvDecodePkg::OPC_OPIMM, rvDecodePkg::OPC_OP};
        foreach (opcs[k]) begin
            for (int f = 0; f < 16; f++) begin
                sendInst({1'b0, f[3], 5'd0, 5'd2, 5'd1, f[2:0], 5'd3, opcs[k]},
                         32'h2000, 1'b0, 1'b0, '0, '0);
            end
        end
        sendInst(32'h40208233, 32'h2004, 1'b0, 1'b0, '0, '0);
        checkEq(32'(exOp), 32'(rvDecodePkg::SUB), "exOp for SUB");
        sendInst(32'h0020827f, 32'h2008, 1'b0, 1'b0, '0, '0);     // Unknown opcode
        checkEq(32'(exOp), 32'(rvDecodePkg::NOP), "exOp for unknown opcode");
    endtask

    task automatic operandTest();
        idleCycle(1'b1, 5'd5, 32'h1234_5678);
        idleCycle(1'b1, 5'd6, 32'h8765_4321);
        sendInst(32'h006283b3, 32'h3000, 1'b0, 1'b0, '0, '0);     // add x7, x5, x6
        sendInst(32'h00000013, 32'h3004, 1'b0, 1'b1, 5'd0, 32'hdead_beef);
        sendInst(32'h00000033, 32'h3008, 1'b0, 1'b0, '0, '0);     // Reads x0 twice
        checkEq(exRs1Val, '0, "x0 after write to x0");
        sendInst(32'h00840533, 32'h300c, 1'b0, 1'b1, 5'd8, 32'hcafe_f00d);
        checkEq(exRs2Val, 32'hcafe_f00d, "bypass of same-cycle write");
        idleCycle(1'b0, '0, '0);
        checkEq(32'(exEn), 32'd0, "exEn after gap cycle");
    endtask

    task automatic stallTest();
        rvDecodePkg::instT last;
        rvDecodePkg::wordT r1;
        rvDecodePkg::wordT r2;
        last = 32'h00a28593;                  // addi x11, x5, 10
        r1 = readModel(last[19:15], 1'b0, '0, '0);
        r2 = readModel(last[24:20], 1'b0, '0, '0);
        sendInst(last, 32'h4000, rvDecodePkg::DO_JUMP, 1'b0, '0, '0);
        rdy = 1'b0;
        fetchPd = rvDecodePkg::NOT_JUMP;
        for (int c = 0; c < 4; c++) begin
            fetchInst = randBits(32);
            fetchPc = 32'h4100 + 32'(c * 4);
            @(posedge clk);
            #1;
            expectEx(1'b1, modelOp(last), 32'h4000, modelImm(last), r1, r2, last[11:7],
                     rvDecodePkg::DO_JUMP);
        end
        sendInst(32'h40535613, 32'h4200, rvDecodePkg::NOT_JUMP, 1'b0, '0, '0);
    endtask

    task automatic randomTest();
        logic [6:0]  opcs [10];
        logic [31:0] r;
        opcs = '{rvDecodePkg::OPC_LUI, rvDecodePkg::OPC_AUIPC, rvDecodePkg::OPC_JAL,
                 rvDecodePkg::OPC_JALR, rvDecodePkg::OPC_BRANCH, rvDecodePkg::OPC_LOAD,
                 rvDecodePkg::OPC_STORE, rvDecodePkg::OPC_OPIMM, rvDecodePkg::OPC_OP, 7'h7f};
        for (int n = 0; n < 200; n++) begin
            r = randBits(25);
            sendInst({r[24:0], opcs[randBits(4) % 10]}, randBits(32), nextBit(),
                     nextBit(), 5'(randBits(5)), randBits(32));
        end
        fetchEn = 1'b0;
        wbEn = 1'b0;
    endtask

    // ====================================================================
    // Main sequence and watchdog
    // ====================================================================
    initial begin
        rst = 1'b1;
        rdy = 1'b1;
        fetchEn = 1'b0;
        fetchInst = '0;
        fetchPc = '0;
        fetchPd = rvDecodePkg::NOT_JUMP;
        wbEn = 1'b0;
        wbRd = '0;
        wbData = '0;
        foreach (shadow[k]) shadow[k] = '0;
        resetTest();
        immFormatTest();
        opMapTest();
        operandTest();
        stallTest();
        randomTest();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * 8);
        $display("Timeout: the tests did not finish in the expected time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== decodeStage.f ====
logic/rvDecodePkg.sv
logic/decodeBus.sv
logic/instDecoder.sv
logic/regFile.sv
logic/operandIssue.sv
logic/decodeStage.sv
tests/decodeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f decodeStage.f \
    --top-module decodeStageTb \
    -o simv

./obj_dir/simv | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
